//--- pmu_ahb.f
+incdir+source
source/pmu_pkg.sv
source/ahb_slave_port.sv
source/pmu_counter_bank.sv
source/pmu_quota_monitor.sv
source/pmu_ahb.sv
verif/tb_pmu_ahb.sv

//--- verif/tb_pmu_ahb.sv
//----------------------------------------------------------
// PMU testbench with random AHB and event stimulus
// checked against a cycle model
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

module tb_pmu_ahb
    import pmu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Interrupt pair as sampled from the DUT
    typedef struct packed {
        logic overflow;
        logic quota;
    } intr_pair_t;

    localparam logic [1:0] OKAY_RESP = 2'b00;
    localparam logic [`PMU_DATA_W-1:0] ALL_ONES = '1;

    // Phase lengths in cycles that set the run limit
    localparam int RST_CYCLES = 8;
    localparam int RB_ITER    = 24;
    localparam int CNT_ITER   = 20;
    localparam int OVF_ITER   = 40;
    localparam int QUOTA_ITER = 30;
    localparam int IDLE_ITER  = 30;
    localparam int MAX_CYCLES = RST_CYCLES + (1 + 4 * RB_ITER) + (3 + 5 * CNT_ITER) +
                                (5 + 2 * OVF_ITER + 10) + (5 + QUOTA_ITER + 6) +
                                (8 + IDLE_ITER + 17) + 50;

    logic                       clk;
    logic                       rstn;
    ahb_req_t                   ahb_req;
    ahb_rsp_t                   ahb_rsp;
    logic [`PMU_N_EVENTS-1:0]   events;
    logic                       intr_ovf;
    logic                       intr_quota;

    integer                     seed = 46758;
    int                         cycles = 0;
    int                         checks = 0;
    int                         rsp_errs = 0;
    int                         intr_errs = 0;
    logic [`PMU_DATA_W-1:0]     pend_wdata = '0;

    // ---------------------------------------------------------
    // Cycle model state
    // ---------------------------------------------------------
    logic                                      m_en = 1'b0;
    logic [`PMU_N_COUNTERS*`PMU_EVSEL_W-1:0]   m_evsel = '0;
    logic [`PMU_DATA_W-1:0]                    m_qlimit = '0;
    logic [`PMU_N_EVENTS-1:0]                  m_qmask = '0;
    cnt_array_t                                m_cnt = '0;
    logic [`PMU_N_COUNTERS-1:0]                m_ovf = '0;
    logic [`PMU_DATA_W-1:0]                    m_acc = '0;
    logic                                      m_aph_valid = 1'b0;
    logic                                      m_aph_write = 1'b0;
    logic [`PMU_REG_IDX_W-1:0]                 m_aph_idx = '0;

    pmu_ahb uut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .ahb_i           (ahb_req),
        .ahb_o           (ahb_rsp),
        .events_i        (events),
        .intr_overflow_o (intr_ovf),
        .intr_quota_o    (intr_quota)
    );

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout, run passed %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ---------------------------------------------------------
    // Model
    // ---------------------------------------------------------

    // Register value a read of this index should return
    function automatic logic [`PMU_DATA_W-1:0] expected_read(input logic [3:0] idx);
        logic [`PMU_DATA_W-1:0] v;
        v = '0;
        if (idx == `PMU_REG_CFG) begin
            v[`PMU_CFG_EN_BIT] = m_en;
        end else if (idx >= `PMU_REG_CNT_BASE && idx < `PMU_REG_CNT_BASE + `PMU_N_COUNTERS) begin
            v = m_cnt[idx - `PMU_REG_CNT_BASE];
        end else if (idx == `PMU_REG_EVSEL) begin
            v[`PMU_N_COUNTERS*`PMU_EVSEL_W-1:0] = m_evsel;
        end else if (idx == `PMU_REG_QLIMIT) begin
            v = m_qlimit;
        end else if (idx == `PMU_REG_QMASK) begin
            v[`PMU_N_EVENTS-1:0] = m_qmask;
        end else if (idx == `PMU_REG_STATUS) begin
            v[`PMU_N_COUNTERS-1:0] = m_ovf;
            v[`PMU_N_COUNTERS]     = (m_acc > m_qlimit);
        end
        return v;
    endfunction

    // Advance the model by one rising edge
    task automatic model_update(input ahb_req_t req, input logic [`PMU_N_EVENTS-1:0] ev);
        logic                   wr;
        logic                   clr;
        logic [`PMU_DATA_W-1:0] d;
        logic [`PMU_DATA_W:0]   sum;
        int                     hits;
        wr  = m_aph_valid && m_aph_write;
        d   = req.hwdata;
        clr = wr && (m_aph_idx == `PMU_REG_CFG) && d[`PMU_CFG_CLR_BIT];
        // Counters with clear over preset over increment
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            if (clr) begin
                m_cnt[i] = '0;
                m_ovf[i] = 1'b0;
            end else if (wr && m_aph_idx == `PMU_REG_CNT_BASE + i) begin
                m_cnt[i] = d;
            end else if (m_en && ev[m_evsel[`PMU_EVSEL_W*i +: `PMU_EVSEL_W]]) begin
                if (m_cnt[i] == ALL_ONES) begin
                    m_ovf[i] = 1'b1;
                end
                m_cnt[i] = m_cnt[i] + 1;
            end
        end
        // Saturating quota accumulator
        hits = 0;
        for (int j = 0; j < `PMU_N_EVENTS; j++) begin
            if (ev[j] && m_qmask[j]) begin
                hits++;
            end
        end
        sum = {1'b0, m_acc} + hits;
        if (clr) begin
            m_acc = '0;
        end else if (m_en) begin
            m_acc = sum[`PMU_DATA_W] ? ALL_ONES : sum[`PMU_DATA_W-1:0];
        end
        // Config registers take the new value after counting
        if (wr) begin
            case (m_aph_idx)
                `PMU_REG_CFG:    m_en     = d[`PMU_CFG_EN_BIT];
                `PMU_REG_EVSEL:  m_evsel  = d[`PMU_N_COUNTERS*`PMU_EVSEL_W-1:0];
                `PMU_REG_QLIMIT: m_qlimit = d;
                `PMU_REG_QMASK:  m_qmask  = d[`PMU_N_EVENTS-1:0];
                default: ;
            endcase
        end
        m_aph_valid = req.hsel && req.hreadyi && (req.htrans == NONSEQ || req.htrans == SEQ);
        m_aph_write = req.hwrite;
        m_aph_idx   = req.haddr[5:2];
    endtask

    // ---------------------------------------------------------
    // Compare tasks
    // ---------------------------------------------------------
    task automatic check_rsp(input ahb_rsp_t got, input ahb_rsp_t exp, input logic data_valid);
        checks++;
        if (got.hreadyo !== exp.hreadyo) begin
            $display("FAIL hreadyo got %h exp %h", got.hreadyo, exp.hreadyo);
            rsp_errs++;
        end
        if (got.hresp !== exp.hresp) begin
            $display("FAIL hresp got %h exp %h", got.hresp, exp.hresp);
            rsp_errs++;
        end
        if (data_valid && got.hrdata !== exp.hrdata) begin
            $display("FAIL hrdata idx %h got %h exp %h", m_aph_idx, got.hrdata, exp.hrdata);
            rsp_errs++;
        end
    endtask

    task automatic check_intr(input intr_pair_t got, input intr_pair_t exp);
        checks++;
        if (got.overflow !== exp.overflow) begin
            $display("FAIL intr_overflow_o got %h exp %h", got.overflow, exp.overflow);
            intr_errs++;
        end
        if (got.quota !== exp.quota) begin
            $display("FAIL intr_quota_o got %h exp %h", got.quota, exp.quota);
            intr_errs++;
        end
    endtask

    // ---------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------

    // One bus cycle entered just after a rising edge
    task automatic run_cycle(input ahb_req_t req);
        logic [`PMU_N_EVENTS-1:0] ev;
        ahb_rsp_t                 exp_rsp;
        intr_pair_t               exp_intr;
        intr_pair_t               got_intr;
        ev      = `PMU_N_EVENTS'($random(seed));
        ahb_req = req;
        events  = ev;
        // Outputs are settled by the falling edge
        @(negedge clk);
        exp_rsp.hreadyo   = 1'b1;
        exp_rsp.hresp     = OKAY_RESP;
        exp_rsp.hrdata    = expected_read(m_aph_idx);
        exp_intr.overflow = |m_ovf;
        exp_intr.quota    = (m_acc > m_qlimit);
        got_intr.overflow = intr_ovf;
        got_intr.quota    = intr_quota;
        check_rsp(ahb_rsp, exp_rsp, m_aph_valid && !m_aph_write);
        check_intr(got_intr, exp_intr);
        @(posedge clk);
        model_update(req, ev);
        #1;
    endtask

    // Address phase whose hwdata carries the previous write's data
    task automatic issue(input logic sel, input htrans_e tr, input logic wr,
                         input logic [3:0] idx, input logic [`PMU_DATA_W-1:0] wdata);
        ahb_req_t req;
        req.hsel        = sel;
        req.hreadyi     = 1'b1;
        req.htrans      = tr;
        // Random upper address bits since only 5:2 decode
        req.haddr       = $random(seed);
        req.haddr[5:2]  = idx;
        req.haddr[1:0]  = 2'b00;
        req.hwrite      = wr;
        req.hwdata      = pend_wdata;
        pend_wdata      = wr ? wdata : $random(seed);
        run_cycle(req);
    endtask

    // NONSEQ or SEQ at random
    function automatic htrans_e active_trans();
        return ($random(seed) & 1) ? SEQ : NONSEQ;
    endfunction

    task automatic wr_reg(input logic [3:0] idx, input logic [`PMU_DATA_W-1:0] data);
        issue(1'b1, active_trans(), 1'b1, idx, data);
    endtask

    task automatic rd_reg(input logic [3:0] idx);
        issue(1'b1, active_trans(), 1'b0, idx, '0);
    endtask

    task automatic idle();
        issue(1'b0, IDLE, 1'b0, '0, '0);
    endtask

    initial begin
        int unsigned             r;
        logic [3:0]              idx;
        logic [`PMU_DATA_W-1:0]  d;
        clk     = 1'b0;
        rstn    = 1'b0;
        ahb_req = '0;
        events  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Register read-back with counting off
        wr_reg(`PMU_REG_CFG, 32'h0);
        for (int k = 0; k < RB_ITER; k++) begin
            idx = 4'($random(seed) & 7);
            d   = $random(seed);
            if (idx == `PMU_REG_CFG) begin
                d[`PMU_CFG_EN_BIT] = 1'b0;
            end
            wr_reg(idx, d);
            rd_reg(idx);
            r = $random(seed);
            rd_reg(4'(9 + r % 7));
            rd_reg(`PMU_REG_STATUS);
        end

        // Event counting
        wr_reg(`PMU_REG_EVSEL, $random(seed));
        wr_reg(`PMU_REG_CFG, 32'h1);
        idle();
        for (int k = 0; k < CNT_ITER; k++) begin
            for (int c = 0; c < `PMU_N_COUNTERS; c++) begin
                rd_reg(4'(`PMU_REG_CNT_BASE + c));
            end
            if (k % 4 == 3) begin
                wr_reg(`PMU_REG_EVSEL, $random(seed));
            end
        end

        // Overflow with presets just below the wrap point
        for (int c = 0; c < `PMU_N_COUNTERS; c++) begin
            wr_reg(4'(`PMU_REG_CNT_BASE + c), 32'hFFFF_FFF0 | ($random(seed) & 15));
        end
        idle();
        for (int k = 0; k < OVF_ITER; k++) begin
            rd_reg(`PMU_REG_STATUS);
            rd_reg(4'(`PMU_REG_CNT_BASE + (k % `PMU_N_COUNTERS)));
        end
        // Flags are sticky across new presets
        for (int c = 0; c < `PMU_N_COUNTERS; c++) begin
            wr_reg(4'(`PMU_REG_CNT_BASE + c), 32'h0);
        end
        repeat (6) rd_reg(`PMU_REG_STATUS);

        // Quota with a fresh accumulator and a small limit
        wr_reg(`PMU_REG_CFG, 32'h3);
        wr_reg(`PMU_REG_QMASK, $random(seed) | 32'h1);
        wr_reg(`PMU_REG_QLIMIT, 16 + ($random(seed) & 31));
        idle();
        for (int k = 0; k < QUOTA_ITER; k++) begin
            rd_reg(`PMU_REG_STATUS);
        end
        // A huge limit drops the interrupt
        wr_reg(`PMU_REG_QLIMIT, ALL_ONES);
        repeat (5) rd_reg(`PMU_REG_STATUS);

        // Clear followed by idle traffic that must leave all registers alone
        wr_reg(`PMU_REG_CFG, 32'h2);
        rd_reg(`PMU_REG_STATUS);
        for (int c = 0; c < `PMU_N_COUNTERS; c++) begin
            rd_reg(4'(`PMU_REG_CNT_BASE + c));
        end
        idle();
        for (int k = 0; k < IDLE_ITER; k++) begin
            r   = $random(seed);
            idx = 4'($random(seed));
            d   = $random(seed);
            case (r % 3)
                0: issue(1'b0, NONSEQ, 1'b1, idx, d);
                1: issue(1'b1, IDLE, 1'b1, idx, d);
                default: issue(1'b1, BUSY, 1'b1, idx, d);
            endcase
        end
        for (int i = 0; i < 16; i++) begin
            rd_reg(4'(i));
        end
        idle();

        $display("checks %0d, read errors %0d, interrupt errors %0d",
                 checks, rsp_errs, intr_errs);
        if (rsp_errs + intr_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/pmu_ahb.sv
//----------------------------------------------------------
// PMU top level behind an AHB-lite slave port
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

module pmu_ahb
    import pmu_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    // AHB-lite slave
    input  wire ahb_req_t                 ahb_i,
    output ahb_rsp_t                      ahb_o,
    // SoC event lines
    input  wire logic [`PMU_N_EVENTS-1:0] events_i,
    // Level interrupts
    output logic                          intr_overflow_o,
    output logic                          intr_quota_o
);

    // Port to counting units
    pmu_wreq_t                   wreq;
    pmu_ctrl_t                   ctrl;

    // Counting units back to the port
    cnt_array_t                  counters;
    logic [`PMU_N_COUNTERS-1:0]  ovf_flags;
    logic                        quota_exceeded;

    // ---------------------------------------------------------
    // Bus port and configuration
    // ---------------------------------------------------------
    ahb_slave_port u_port (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .ahb_i            (ahb_i),
        .counters_i       (counters),
        .ovf_flags_i      (ovf_flags),
        .quota_exceeded_i (quota_exceeded),
        .wreq_o           (wreq),
        .ctrl_o           (ctrl),
        .ahb_o            (ahb_o),
        .intr_overflow_o  (intr_overflow_o),
        .intr_quota_o     (intr_quota_o)
    );

    // ---------------------------------------------------------
    // Counting units, side by side
    // ---------------------------------------------------------
    pmu_counter_bank u_cnt (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .events_i    (events_i),
        .wreq_i      (wreq),
        .ctrl_i      (ctrl),
        .counters_o  (counters),
        .ovf_flags_o (ovf_flags)
    );

    pmu_quota_monitor u_quota (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .events_i         (events_i),
        .ctrl_i           (ctrl),
        .quota_exceeded_o (quota_exceeded)
    );

endmodule

`default_nettype wire

//--- source/pmu_quota_monitor.sv
//----------------------------------------------------------
// Masked event accumulator checked against a quota limit
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

module pmu_quota_monitor
    import pmu_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rstn_i,
    // SoC event lines
    input  wire logic [`PMU_N_EVENTS-1:0] events_i,
    // Live settings, uses enable, clear, mask and limit
    input  wire pmu_ctrl_t                ctrl_i,
    output logic                          quota_exceeded_o
);

    // Enough bits to count every event line high at once
    localparam int EV_CNT_W = $clog2(`PMU_N_EVENTS + 1);

    logic [EV_CNT_W-1:0]     ev_cnt;
    logic [`PMU_DATA_W:0]    sum;
    logic [`PMU_DATA_W-1:0]  acc_q;

    // Number of masked event lines high this cycle
    always_comb begin
        ev_cnt = '0;
        for (int i = 0; i < `PMU_N_EVENTS; i++) begin
            ev_cnt = ev_cnt + EV_CNT_W'(events_i[i] & ctrl_i.qmask[i]);
        end
    end

    // One extra bit catches the carry out for saturation
    assign sum = {1'b0, acc_q} + (`PMU_DATA_W + 1)'(ev_cnt);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            acc_q <= '0;
        end else if (ctrl_i.clear) begin
            acc_q <= '0;
        end else if (ctrl_i.enable) begin
            // Stick at all ones rather than wrap
            acc_q <= sum[`PMU_DATA_W] ? '1 : sum[`PMU_DATA_W-1:0];
        end
    end

    // Strictly above the limit
    assign quota_exceeded_o = (acc_q > ctrl_i.qlimit);

endmodule

`default_nettype wire

//--- source/pmu_counter_bank.sv
//----------------------------------------------------------
// Event counters with preset, clear and sticky overflow
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

module pmu_counter_bank
    import pmu_pkg::*;
(
    input  wire logic                       clk_i,
    input  wire logic                       rstn_i,
    // SoC event lines
    input  wire logic [`PMU_N_EVENTS-1:0]   events_i,
    // Register write and live settings from the port
    input  wire pmu_wreq_t                  wreq_i,
    input  wire pmu_ctrl_t                  ctrl_i,
    output cnt_array_t                      counters_o,
    output logic [`PMU_N_COUNTERS-1:0]      ovf_flags_o
);

    cnt_array_t                  cnt_q;
    logic [`PMU_N_COUNTERS-1:0]  ovf_q;

    // Per-counter write hit and increment request
    logic [`PMU_N_COUNTERS-1:0]  cnt_wr;
    logic [`PMU_N_COUNTERS-1:0]  cnt_inc;

    // ---------------------------------------------------------
    // Decode
    // ---------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            // Counter i sits at register index CNT_BASE + i
            cnt_wr[i]  = wreq_i.valid &&
                         (wreq_i.idx == `PMU_REG_IDX_W'(`PMU_REG_CNT_BASE + i));
            // Event line picked by this counter's select field
            cnt_inc[i] = ctrl_i.enable && events_i[ctrl_i.evsel[i]];
        end
    end

    // ---------------------------------------------------------
    // Counters and flags
    // ---------------------------------------------------------

    // Priority is clear, then preset write, then increment
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
            ovf_q <= '0;
        end else if (ctrl_i.clear) begin
            cnt_q <= '0;
            ovf_q <= '0;
        end else begin
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (cnt_wr[i]) begin
                    // Preset uses the raw view of the write word
                    cnt_q[i] <= wreq_i.data.raw;
                end else if (cnt_inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                    // Wrap from all ones, flag stays until a clear
                    if (&cnt_q[i]) begin
                        ovf_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    assign counters_o  = cnt_q;
    assign ovf_flags_o = ovf_q;

endmodule

`default_nettype wire

//--- source/ahb_slave_port.sv
//----------------------------------------------------------
// AHB-lite zero-wait slave port and PMU configuration regs
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

module ahb_slave_port
    import pmu_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    // AHB request from the master
    input  wire ahb_req_t                  ahb_i,
    // Results from the counter bank and quota monitor
    input  wire cnt_array_t                counters_i,
    input  wire logic [`PMU_N_COUNTERS-1:0] ovf_flags_i,
    input  wire logic                      quota_exceeded_i,
    // Towards the counting units
    output pmu_wreq_t                      wreq_o,
    output pmu_ctrl_t                      ctrl_o,
    // AHB response and interrupts
    output ahb_rsp_t                       ahb_o,
    output logic                           intr_overflow_o,
    output logic                           intr_quota_o
);

    // Registered address phase
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`PMU_REG_IDX_W-1:0] idx;
    } aph_t;

    aph_t                                         aph_q;
    logic                                         accept;
    pmu_wreq_t                                    wreq;

    // Configuration registers
    logic                                         cfg_en_q;
    logic [`PMU_N_COUNTERS-1:0][`PMU_EVSEL_W-1:0] evsel_q;
    logic [`PMU_DATA_W-1:0]                       qlimit_q;
    logic [`PMU_N_EVENTS-1:0]                     qmask_q;

    logic [`PMU_DATA_W-1:0]                       rdata;

    // ---------------------------------------------------------
    // Address phase
    // ---------------------------------------------------------

    // Only NONSEQ and SEQ carry a transfer, IDLE and BUSY are dropped
    assign accept = ahb_i.hsel && ahb_i.hreadyi &&
                    (ahb_i.htrans == NONSEQ || ahb_i.htrans == SEQ);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            aph_q <= '0;
        end else begin
            aph_q.valid <= accept;
            aph_q.write <= ahb_i.hwrite;
            // Word index from haddr[5:2]
            aph_q.idx   <= ahb_i.haddr[`PMU_REG_IDX_W+1:2];
        end
    end

    // ---------------------------------------------------------
    // Data phase write
    // ---------------------------------------------------------

    // hwdata belongs to the data phase, so the request is combinational
    assign wreq.valid    = aph_q.valid && aph_q.write;
    assign wreq.idx      = aph_q.idx;
    assign wreq.data.raw = ahb_i.hwdata;
    assign wreq_o        = wreq;

    // Writes to counters go to the bank, STATUS and unmapped are dropped
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_en_q <= 1'b0;
            evsel_q  <= '0;
            qlimit_q <= '0;
            qmask_q  <= '0;
        end else if (wreq.valid) begin
            case (wreq.idx)
                `PMU_REG_IDX_W'(`PMU_REG_CFG): begin
                    cfg_en_q <= wreq.data.cfg.enable;
                end
                `PMU_REG_IDX_W'(`PMU_REG_EVSEL): begin
                    evsel_q <= wreq.data.raw[`PMU_N_COUNTERS*`PMU_EVSEL_W-1:0];
                end
                `PMU_REG_IDX_W'(`PMU_REG_QLIMIT): begin
                    qlimit_q <= wreq.data.raw;
                end
                `PMU_REG_IDX_W'(`PMU_REG_QMASK): begin
                    qmask_q <= wreq.data.raw[`PMU_N_EVENTS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Clear is a single-cycle strobe taken straight from the CFG write
    assign ctrl_o.clear  = wreq.valid && wreq.data.cfg.clear &&
                           (wreq.idx == `PMU_REG_IDX_W'(`PMU_REG_CFG));
    assign ctrl_o.enable = cfg_en_q;
    assign ctrl_o.evsel  = evsel_q;
    assign ctrl_o.qmask  = qmask_q;
    assign ctrl_o.qlimit = qlimit_q;

    // ---------------------------------------------------------
    // Data phase read
    // ---------------------------------------------------------
    always_comb begin
        rdata = '0;
        if (aph_q.valid && !aph_q.write) begin
            case (aph_q.idx)
                `PMU_REG_IDX_W'(`PMU_REG_CFG): begin
                    rdata[`PMU_CFG_EN_BIT]  = cfg_en_q;
                    // Clear is never stored
                    rdata[`PMU_CFG_CLR_BIT] = 1'b0;
                end
                `PMU_REG_IDX_W'(`PMU_REG_EVSEL): begin
                    rdata = `PMU_DATA_W'(evsel_q);
                end
                `PMU_REG_IDX_W'(`PMU_REG_QLIMIT): begin
                    rdata = qlimit_q;
                end
                `PMU_REG_IDX_W'(`PMU_REG_QMASK): begin
                    rdata = `PMU_DATA_W'(qmask_q);
                end
                `PMU_REG_IDX_W'(`PMU_REG_STATUS): begin
                    rdata = `PMU_DATA_W'({quota_exceeded_i, ovf_flags_i});
                end
                default: begin
                    // Counter window, anything else reads zero
                    for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                        if (aph_q.idx == `PMU_REG_IDX_W'(`PMU_REG_CNT_BASE + i)) begin
                            rdata = counters_i[i];
                        end
                    end
                end
            endcase
        end
    end

    // Zero wait states, always OKAY
    assign ahb_o.hreadyo = 1'b1;
    assign ahb_o.hresp   = HRESP_OKAY;
    assign ahb_o.hrdata  = rdata;

    // Level interrupts from registered flags
    assign intr_overflow_o = |ovf_flags_i;
    assign intr_quota_o    = quota_exceeded_i;

endmodule

`default_nettype wire

//--- source/pmu_pkg.sv
//----------------------------------------------------------
// PMU types for the AHB-lite port, control and registers
//----------------------------------------------------------
`default_nettype none

`include "pmu_defines.svh"

package pmu_pkg;

    // AHB transfer type, SEQ is treated like NONSEQ by the slave
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // OKAY response code, the only one this slave returns
    localparam logic [1:0] HRESP_OKAY = 2'b00;

    // Master to slave, burst, size, prot and lock left out
    typedef struct packed {
        logic                   hsel;
        logic                   hreadyi;
        htrans_e                htrans;
        logic [`PMU_ADDR_W-1:0] haddr;
        logic                   hwrite;
        logic [`PMU_DATA_W-1:0] hwdata;
    } ahb_req_t;

    // Slave to master
    typedef struct packed {
        logic                   hreadyo;
        logic [1:0]             hresp;
        logic [`PMU_DATA_W-1:0] hrdata;
    } ahb_rsp_t;

    // Configuration word, enable in bit 0 and clear in bit 1
    typedef struct packed {
        logic [`PMU_DATA_W-3:0] reserved;
        logic                   clear;
        logic                   enable;
    } pmu_cfg_t;

    // Write data seen either as config fields or as a counter preset
    typedef union packed {
        pmu_cfg_t               cfg;
        logic [`PMU_DATA_W-1:0] raw;
    } pmu_wdata_u;

    // Write request, valid in the data phase cycle
    typedef struct packed {
        logic                      valid;
        logic [`PMU_REG_IDX_W-1:0] idx;
        pmu_wdata_u                data;
    } pmu_wreq_t;

    // Live settings shared by the counter bank and quota monitor
    typedef struct packed {
        logic                                        enable;
        logic                                        clear;
        logic [`PMU_N_COUNTERS-1:0][`PMU_EVSEL_W-1:0] evsel;
        logic [`PMU_N_EVENTS-1:0]                    qmask;
        logic [`PMU_DATA_W-1:0]                      qlimit;
    } pmu_ctrl_t;

    // All counter values, counter 0 in the low word
    typedef logic [`PMU_N_COUNTERS-1:0][`PMU_DATA_W-1:0] cnt_array_t;

endpackage

`default_nettype wire

//--- source/pmu_defines.svh
//----------------------------------------------------------
// PMU global widths, counts and register map
//----------------------------------------------------------
`ifndef PMU_DEFINES_SVH
`define PMU_DEFINES_SVH

// ---------------------------------------------------------
// Bus and datapath widths
// ---------------------------------------------------------
`define PMU_DATA_W      32
`define PMU_ADDR_W      32

// Counter and event line counts
`define PMU_N_COUNTERS  4
`define PMU_N_EVENTS    8

// One event-select field, enough to address every event line
`define PMU_EVSEL_W     3

// Word index into the register map, taken from haddr[5:2]
`define PMU_REG_IDX_W   4

// ---------------------------------------------------------
// Register map (word indices)
// ---------------------------------------------------------
`define PMU_REG_CFG       0
// Counters occupy CNT_BASE up to CNT_BASE + N_COUNTERS - 1
`define PMU_REG_CNT_BASE  1
`define PMU_REG_EVSEL     5
`define PMU_REG_QLIMIT    6
`define PMU_REG_QMASK     7
// Read-only status, overflow flags low and quota flag above
`define PMU_REG_STATUS    8
// Indices 9 to 15 are unmapped

// Bit positions inside the configuration word
`define PMU_CFG_EN_BIT    0
`define PMU_CFG_CLR_BIT   1

`endif
